//--- rsa_pkg.sv
////////////////////
// Operand widths, operand types and controller states
////////////////////
`default_nettype none

package rsa_pkg;

    // Operand, modulus and result width
    localparam int mod_width = 16;

    // Exponent width
    localparam int exp_width = 4;

    // Operands, modulus and result
    typedef logic [mod_width-1:0] mod_t;

    // Exponent value
    typedef logic [exp_width-1:0] exp_t;

    // Square and multiply sequencer states
    typedef enum logic [2:0] {
        idle,
        check,
        mult,
        square,
        finish
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- modexp_ctrl.sv
////////////////////
// Modular exponentiation controller FSM
// Right-to-left square and multiply sequencing
////////////////////
`timescale 1ns/1ps
`default_nettype none

module modexp_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  wire  rsa_start,
    input  wire  exp_bit,
    input  wire  exp_empty,
    input  wire  mult_done,
    output logic load_operands,
    output logic load_exp,
    output logic shift_exp,
    output logic sel_square,
    output logic mult_start,
    output logic write_acc,
    output logic write_base,
    output logic write_result,
    output logic rsa_done
);

    import rsa_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    // State register and done pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            rsa_done <= 1'b0;
        end else begin
            state    <= state_next;
            // Result register is written in finish, so done follows one cycle later
            rsa_done <= (state == finish);
        end
    end

    // Next state and single-cycle strobes
    always_comb begin
        state_next    = state;
        load_operands = 1'b0;
        load_exp      = 1'b0;
        shift_exp     = 1'b0;
        sel_square    = 1'b0;
        mult_start    = 1'b0;
        write_acc     = 1'b0;
        write_base    = 1'b0;
        write_result  = 1'b0;

        case (state)
            idle: begin
                // Start is only honoured here
                if (rsa_start) begin
                    load_operands = 1'b1;
                    load_exp      = 1'b1;
                    state_next    = check;
                end
            end

            check: begin
                if (exp_empty) begin
                    state_next = finish;
                end else begin
                    mult_start = 1'b1;
                    if (exp_bit) begin
                        // Accumulator times base first
                        state_next = mult;
                    end else begin
                        // Bit clear, square only
                        sel_square = 1'b1;
                        state_next = square;
                    end
                end
            end

            mult: begin
                if (mult_done) begin
                    // Capture the product and launch the square in the same cycle
                    write_acc  = 1'b1;
                    mult_start = 1'b1;
                    sel_square = 1'b1;
                    state_next = square;
                end
            end

            square: begin
                if (mult_done) begin
                    write_base = 1'b1;
                    shift_exp  = 1'b1;
                    state_next = check;
                end
            end

            finish: begin
                write_result = 1'b1;
                state_next   = idle;
            end

            default: begin
                state_next = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- exp_bit_counter.sv
////////////////////
// Exponent shift register with bit and empty flags
////////////////////
`timescale 1ns/1ps
`default_nettype none

module exp_bit_counter (
    input  wire           clk,
    input  wire           rst,
    input  wire           load_exp,
    input  wire           shift_exp,
    input  wire  rsa_pkg::exp_t exponent,
    output logic          exp_bit,
    output logic          exp_empty
);

    import rsa_pkg::*;

    // Exponent bits still to be processed
    exp_t exp_rem;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_rem <= '0;
        end else if (load_exp) begin
            exp_rem <= exponent;
        end else if (shift_exp) begin
            // Drop the bit just processed
            exp_rem <= {1'b0, exp_rem[exp_width-1:1]};
        end
    end

    // Current bit, least significant first
    assign exp_bit = exp_rem[0];

    // Loop ends once no set bits remain
    assign exp_empty = (exp_rem == '0);

endmodule

`default_nettype wire

//--- mod_mult.sv
////////////////////
// Bit-serial interleaved modular multiplier
// One bit of operand_a per cycle, MSB first
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mod_mult (
    input  wire           clk,
    input  wire           rst,
    input  wire           mult_start,
    input  wire  rsa_pkg::mod_t operand_a,
    input  wire  rsa_pkg::mod_t operand_b,
    input  wire  rsa_pkg::mod_t modulus,
    output rsa_pkg::mod_t product,
    output logic          mult_done
);

    import rsa_pkg::*;

    // Operands latched at start
    mod_t a_reg;
    mod_t b_reg;
    mod_t m_reg;

    // Partial remainder, kept below the modulus
    mod_t rem;
    mod_t rem_next;

    logic busy;
    logic [$clog2(mod_width)-1:0] bit_idx;

    // 17-bit intermediates for doubling and addition
    logic [mod_width:0] m_ext;
    logic [mod_width:0] dbl;
    logic [mod_width:0] sum;
    mod_t dbl_red;
    mod_t sum_red;

    always_comb begin
        m_ext = {1'b0, m_reg};

        // Double and reduce once
        dbl = {rem, 1'b0};
        if (dbl >= m_ext) begin
            dbl_red = mod_t'(dbl - m_ext);
        end else begin
            dbl_red = dbl[mod_width-1:0];
        end

        // Add operand_b and reduce once more
        sum = {1'b0, dbl_red} + {1'b0, b_reg};
        if (sum >= m_ext) begin
            sum_red = mod_t'(sum - m_ext);
        end else begin
            sum_red = sum[mod_width-1:0];
        end

        rem_next = a_reg[bit_idx] ? sum_red : dbl_red;
    end

    // Bit index counter and done pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            bit_idx   <= '0;
            mult_done <= 1'b0;
        end else begin
            mult_done <= 1'b0;
            if (mult_start) begin
                busy    <= 1'b1;
                // Top bit index, mod_width is a power of two
                bit_idx <= '1;
            end else if (busy) begin
                bit_idx <= bit_idx - 1'b1;
                if (bit_idx == '0) begin
                    busy      <= 1'b0;
                    mult_done <= 1'b1;
                end
            end
        end
    end

    // Operand latches and remainder
    always_ff @(posedge clk) begin
        if (mult_start) begin
            a_reg <= operand_a;
            b_reg <= operand_b;
            m_reg <= modulus;
            rem   <= '0;
        end else if (busy) begin
            rem <= rem_next;
        end
    end

    // Remainder holds the product until the next start
    assign product = rem;

endmodule

`default_nettype wire

//--- modexp_datapath.sv
////////////////////
// Accumulator, base, modulus and result registers
// Multiplier operand steering
////////////////////
`timescale 1ns/1ps
`default_nettype none

module modexp_datapath (
    input  wire           clk,
    input  wire           rst,
    input  wire           load_operands,
    input  wire           sel_square,
    input  wire           write_acc,
    input  wire           write_base,
    input  wire           write_result,
    input  wire  rsa_pkg::mod_t message,
    input  wire  rsa_pkg::mod_t modulus_in,
    input  wire  rsa_pkg::mod_t product,
    output rsa_pkg::mod_t operand_a,
    output rsa_pkg::mod_t operand_b,
    output rsa_pkg::mod_t modulus,
    output rsa_pkg::mod_t result
);

    import rsa_pkg::*;

    // Running product of selected powers
    mod_t acc;

    // Message raised to successive powers of two
    mod_t base;

    // Modulus for the whole run
    mod_t mod_reg;

    always_ff @(posedge clk) begin
        if (load_operands) begin
            acc     <= {{(mod_width-1){1'b0}}, 1'b1};
            base    <= message;
            mod_reg <= modulus_in;
        end else begin
            if (write_acc) begin
                acc <= product;
            end
            if (write_base) begin
                base <= product;
            end
        end
    end

    // Result register, held until the next finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (write_result) begin
            result <= acc;
        end
    end

    // Square uses base twice, multiply uses accumulator and base
    assign operand_a = sel_square ? base : acc;
    assign operand_b = base;
    assign modulus   = mod_reg;

endmodule

`default_nettype wire

//--- rsa_modexp_top.sv
////////////////////
// Modular exponentiation top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsa_modexp_top (
    input  wire           clk,
    input  wire           rst,
    input  wire  rsa_pkg::mod_t message,
    input  wire  rsa_pkg::mod_t modulus,
    input  wire  rsa_pkg::exp_t exponent,
    input  wire           rsa_start,
    output wire  rsa_pkg::mod_t result,
    output wire           rsa_done
);

    import rsa_pkg::*;

    // Controller strobes
    wire load_operands;
    wire load_exp;
    wire shift_exp;
    wire sel_square;
    wire mult_start;
    wire write_acc;
    wire write_base;
    wire write_result;

    // Exponent status
    wire exp_bit;
    wire exp_empty;

    // Multiplier operands and product
    mod_t operand_a;
    mod_t operand_b;
    mod_t latched_modulus;
    mod_t product;
    wire  mult_done;

    modexp_ctrl modexp_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .rsa_start     (rsa_start),
        .exp_bit       (exp_bit),
        .exp_empty     (exp_empty),
        .mult_done     (mult_done),
        .load_operands (load_operands),
        .load_exp      (load_exp),
        .shift_exp     (shift_exp),
        .sel_square    (sel_square),
        .mult_start    (mult_start),
        .write_acc     (write_acc),
        .write_base    (write_base),
        .write_result  (write_result),
        .rsa_done      (rsa_done)
    );

    exp_bit_counter exp_bit_counter_i (
        .clk       (clk),
        .rst       (rst),
        .load_exp  (load_exp),
        .shift_exp (shift_exp),
        .exponent  (exponent),
        .exp_bit   (exp_bit),
        .exp_empty (exp_empty)
    );

    modexp_datapath modexp_datapath_i (
        .clk           (clk),
        .rst           (rst),
        .load_operands (load_operands),
        .sel_square    (sel_square),
        .write_acc     (write_acc),
        .write_base    (write_base),
        .write_result  (write_result),
        .message       (message),
        .modulus_in    (modulus),
        .product       (product),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .modulus       (latched_modulus),
        .result        (result)
    );

    mod_mult mod_mult_i (
        .clk        (clk),
        .rst        (rst),
        .mult_start (mult_start),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .modulus    (latched_modulus),
        .product    (product),
        .mult_done  (mult_done)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
////////////////////
// Testbench clock source
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period_ns = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 100 ns period
    always #(half_period_ns) clk = ~clk;

endmodule

`default_nettype wire

//--- rsa_modexp_tb.sv
////////////////////
// Testbench for rsa_modexp_top
// Random and directed runs against a modular power model
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsa_modexp_tb;

    import rsa_pkg::*;

    // Cycles allowed for one run to reach rsa_done
    localparam int done_timeout = 1000;
    localparam int random_runs  = 200;

    logic clk;
    logic rst;
    mod_t message;
    mod_t modulus;
    exp_t exponent;
    logic rsa_start;
    mod_t result;
    logic rsa_done;

    logic [31:0] rng_state;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk)
    );

    rsa_modexp_top rsa_modexp_top_i (
        .clk       (clk),
        .rst       (rst),
        .message   (message),
        .modulus   (modulus),
        .exponent  (exponent),
        .rsa_start (rsa_start),
        .result    (result),
        .rsa_done  (rsa_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // Reference model, repeated multiplication in wide integers
    function automatic mod_t model_modpow(input mod_t base, input exp_t power, input mod_t modv);
        longint unsigned acc;
        longint unsigned m;
        longint unsigned n;
        m = 64'(base);
        n = 64'(modv);
        acc = 64'd1 % n;
        for (int i = 0; i < int'(power); i++) begin
            acc = (acc * m) % n;
        end
        return mod_t'(acc);
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_result(input mod_t expected, input mod_t actual);
        if (actual !== expected) begin
            $display("ERR result expected %h actual %h", expected, actual);
            abort_run();
        end
    endtask

    task automatic check_done(input logic expected, input logic actual, input string where);
        if (actual !== expected) begin
            $display("rsa_done was %b %s but should have been %b", actual, where, expected);
            abort_run();
        end
    endtask

    // One start, wait for done, then watch the idle cycles after it
    task automatic run_modexp(
        input mod_t msg,
        input mod_t modv,
        input exp_t expv,
        input logic busy_start,
        input int   idle_cycles
    );
        mod_t expected;
        int   cycles;
        expected = model_modpow(msg, expv, modv);
        @(negedge clk);
        message   = msg;
        modulus   = modv;
        exponent  = expv;
        rsa_start = 1'b1;
        @(negedge clk);
        rsa_start = 1'b0;
        cycles = 0;
        while (rsa_done !== 1'b1) begin
            if (cycles >= done_timeout) begin
                $display("Timed out waiting for rsa_done after %0d cycles", done_timeout);
                abort_run();
            end
            // Second start with other inputs, must be ignored
            if (busy_start && cycles == 4) begin
                message   = msg ^ 16'h5a5a;
                modulus   = modv ^ 16'h0f0f;
                exponent  = expv ^ 4'h5;
                rsa_start = 1'b1;
            end else begin
                rsa_start = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        check_result(expected, result);
        for (int i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            check_done(1'b0, rsa_done, "in an idle cycle after the pulse");
            check_result(expected, result);
        end
    endtask

    initial begin
        logic [31:0] r;
        mod_t        msg;
        mod_t        modv;
        exp_t        expv;

        rst       = 1'b1;
        message   = '0;
        modulus   = '0;
        exponent  = '0;
        rsa_start = 1'b0;
        rng_state = 32'hb83e;

        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Quiet outputs after reset
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_done(1'b0, rsa_done, "after reset");
            check_result(16'h0000, result);
        end

        // Edge exponents
        run_modexp(16'h1234, 16'hbeef, 4'd0, 1'b0, 3);
        run_modexp(16'h1234, 16'hbeef, 4'd1, 1'b0, 3);
        run_modexp(16'hfffe, 16'hffff, 4'd15, 1'b0, 3);

        // Start while busy, long idle watch for a second pulse
        run_modexp(16'h0abc, 16'hc001, 4'd11, 1'b1, done_timeout);

        for (int n = 0; n < random_runs; n++) begin
            next_random(r);
            modv = r[15:0];
            if (modv < 16'd2) begin
                modv = modv + 16'd2;
            end
            next_random(r);
            msg = r[15:0] % modv;
            next_random(r);
            expv = r[3:0];
            run_modexp(msg, modv, expv, 1'b0, 2);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rsa_pkg.sv
modexp_ctrl.sv
exp_bit_counter.sv
mod_mult.sv
modexp_datapath.sv
rsa_modexp_top.sv
tb_clock_gen.sv
rsa_modexp_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = rsa_modexp_tb
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
